//--- filelist.f
+incdir+include
rtl/npu_pkg.sv
rtl/halfword_packer.sv
rtl/sync_fifo.sv
rtl/dot_engine.sv
rtl/npu_top.sv
testbench/tb_npu_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the NPU subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
	--timescale 1ns/1ps \
	--top-module tb_npu_top \
	-Mdir obj_dir \
	-o sim_npu \
	-f filelist.f

# the log decides the outcome
./obj_dir/sim_npu 2>&1 | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "testbench reported a failure, see $LOG"
	exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "run ended without a result line, see $LOG"
	exit 1
fi

exit 0

//--- testbench/tb_npu_top.sv
`timescale 1ns/1ps
`include "npu_consts.svh"

module tb_npu_top import npu_pkg::*; ();

	localparam int CYCLE_LIMIT = 20000; // about four times the planned traffic

	logic        okClk;
	logic        i_reset;
	logic        i_pi_data_write;
	logic [31:0] i_pi_data_word;
	logic        i_pi_weig_write;
	logic [31:0] i_pi_weig_word;
	logic [15:0] i_bias;
	logic        i_engine_enable;
	logic        i_po_read;
	logic        o_pi_data_ready;
	logic        o_pi_weig_ready;
	logic        o_po_ready;
	logic [31:0] o_po_word;

	integer            seed;
	int                cycle_count;
	int                data_to_send; // halfwords still to write per lane
	int                weig_to_send;
	bit                read_on;
	logic signed [15:0] bias_now;
	half_t             data_halves[$];
	half_t             weig_halves[$];
	result_t           exp_q[$];

	npu_top u_dut (
		.okClk           (okClk),
		.i_reset         (i_reset),
		.i_pi_data_write (i_pi_data_write),
		.i_pi_data_word  (i_pi_data_word),
		.o_pi_data_ready (o_pi_data_ready),
		.i_pi_weig_write (i_pi_weig_write),
		.i_pi_weig_word  (i_pi_weig_word),
		.o_pi_weig_ready (o_pi_weig_ready),
		.i_bias          (i_bias),
		.i_engine_enable (i_engine_enable),
		.i_po_read       (i_po_read),
		.o_po_ready      (o_po_ready),
		.o_po_word       (o_po_word)
	);

	always #5 okClk = ~okClk;

	always @(posedge okClk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("SIMULATION FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic abort_run(input string why);
		$display("error at %0t: %s", $time, why);
		$display("SIMULATION FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// reference dot product, one result per complete line pair
	task automatic form_pairs();
		logic signed [31:0] acc;
		logic signed [15:0] dh;
		logic signed [15:0] wh;
		while (data_halves.size() >= `NPU_HALVES_PER_LINE &&
		       weig_halves.size() >= `NPU_HALVES_PER_LINE) begin
			acc = '0;
			for (int k = 0; k < `NPU_HALVES_PER_LINE; k++) begin
				dh  = data_halves.pop_front();
				wh  = weig_halves.pop_front();
				acc = acc + 32'(dh) * 32'(wh); // low 32 bits, wraps like the DUT
			end
			acc = acc + 32'(bias_now); // sign-extended bias
			exp_q.push_back(acc);
		end
	endtask

	// one falling edge: random writes where ready allows, random reads
	task automatic tick();
		@(negedge okClk);
		if (data_to_send > 0 && o_pi_data_ready && (($random(seed) & 3) != 0)) begin
			i_pi_data_write = 1'b1;
			i_pi_data_word  = $random(seed); // upper bits random, ignored by the DUT
			data_halves.push_back(i_pi_data_word[15:0]);
			data_to_send--;
		end else begin
			i_pi_data_write = 1'b0;
		end
		if (weig_to_send > 0 && o_pi_weig_ready && (($random(seed) & 3) != 0)) begin
			i_pi_weig_write = 1'b1;
			i_pi_weig_word  = $random(seed);
			weig_halves.push_back(i_pi_weig_word[15:0]);
			weig_to_send--;
		end else begin
			i_pi_weig_write = 1'b0;
		end
		form_pairs();
		if (read_on && o_po_ready && (($random(seed) & 1) != 0)) begin
			if (exp_q.size() == 0) begin
				abort_run("pipe-out offered a result that the model did not expect");
			end else begin
				i_po_read = 1'b1;
				check_value("o_po_word", exp_q.pop_front(), o_po_word);
			end
		end else begin
			i_po_read = 1'b0;
		end
	endtask

	task automatic send_halves(input int n_data, input int n_weig);
		data_to_send = n_data;
		weig_to_send = n_weig;
		while (data_to_send > 0 || weig_to_send > 0) begin
			tick();
		end
	endtask

	task automatic drain();
		read_on = 1'b1;
		while (exp_q.size() != 0 || data_to_send > 0 || weig_to_send > 0) begin
			tick();
		end
	endtask

	task automatic set_bias(input logic signed [15:0] value);
		@(negedge okClk);
		bias_now = value; // lanes idle and engine drained here
		i_bias   = value;
	endtask

	task automatic apply_reset();
		@(negedge okClk);
		i_reset         = 1'b1;
		i_pi_data_write = 1'b0;
		i_pi_weig_write = 1'b0;
		i_po_read       = 1'b0;
		repeat (2) @(negedge okClk);
		check_value("o_po_ready", 32'd0, 32'(o_po_ready));
		check_value("o_pi_data_ready", 32'd0, 32'(o_pi_data_ready));
		check_value("o_pi_weig_ready", 32'd0, 32'(o_pi_weig_ready));
		i_reset = 1'b0;
		data_halves.delete(); // partial lines are gone in the DUT too
		weig_halves.delete();
		exp_q.delete();
	endtask

	initial begin
		int k_data;
		int k_weig;
		seed            = 19950;
		okClk           = 1'b0;
		i_reset         = 1'b1;
		i_pi_data_write = 1'b0;
		i_pi_data_word  = '0;
		i_pi_weig_write = 1'b0;
		i_pi_weig_word  = '0;
		i_bias          = '0;
		i_engine_enable = 1'b1;
		i_po_read       = 1'b0;
		cycle_count     = 0;
		data_to_send    = 0;
		weig_to_send    = 0;
		read_on         = 1'b1;
		bias_now        = '0;
		apply_reset();

		// random traffic with free reads
		set_bias(16'sd5);
		send_halves(24 * 8, 24 * 8);
		drain();

		// bias changed between batches, extremes included
		set_bias(-16'sd1234);
		send_halves(8 * 8, 8 * 8);
		drain();
		set_bias(16'sh8000);
		send_halves(8 * 8, 8 * 8);
		drain();
		set_bias(16'sh7fff);
		send_halves(8 * 8, 8 * 8);
		drain();

		// engine disabled, pairs must wait in the line FIFOs
		i_engine_enable = 1'b0;
		send_halves(6 * 8, 6 * 8);
		repeat (50) begin
			tick();
			check_value("o_po_ready", 32'd0, 32'(o_po_ready));
		end
		i_engine_enable = 1'b1;
		drain();

		// host stops reading, back-pressure must reach pipe-in ready
		read_on      = 1'b0;
		data_to_send = 48 * 8;
		weig_to_send = 48 * 8;
		repeat (100) tick();
		repeat (700) begin
			tick();
			check_value("o_po_ready", 32'd1, 32'(o_po_ready));
		end
		check_value("o_pi_data_ready", 32'd0, 32'(o_pi_data_ready));
		check_value("o_pi_weig_ready", 32'd0, 32'(o_pi_weig_ready));
		drain();

		// reset in the middle of a line, with a result still waiting unread
		read_on = 1'b0;
		k_data  = 1 + (($random(seed) & 32'h7fffffff) % 7);
		k_weig  = 1 + (($random(seed) & 32'h7fffffff) % 7);
		send_halves(2 * 8 + k_data, 2 * 8 + k_weig);
		while (!o_po_ready) begin
			tick();
		end
		apply_reset();
		read_on = 1'b1;
		set_bias(16'sd77);
		send_halves(10 * 8, 10 * 8);
		drain();

		repeat (20) tick(); // nothing beyond the written pairs may show up
		check_value("o_po_ready", 32'd0, 32'(o_po_ready));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- rtl/npu_top.sv
`timescale 1ns/1ps
`include "npu_consts.svh"

module npu_top import npu_pkg::*; (
	input  logic                       okClk,
	input  logic                       i_reset,
	// data lane pipe-in
	input  logic                       i_pi_data_write,
	input  logic [31:0]                i_pi_data_word,
	output logic                       o_pi_data_ready,
	// weight lane pipe-in
	input  logic                       i_pi_weig_write,
	input  logic [31:0]                i_pi_weig_word,
	output logic                       o_pi_weig_ready,
	input  logic [15:0]                i_bias,
	input  logic                       i_engine_enable,
	// result pipe-out
	input  logic                       i_po_read,
	output logic                       o_po_ready,
	output logic [31:0]                o_po_word
);

	logic                          data_push, weig_push;
	line_t                         data_line_in, weig_line_in;
	line_t                         data_head, weig_head;
	logic                          data_empty, weig_empty;
	logic [`NPU_LINE_COUNT_W-1:0]  data_count, weig_count;
	logic                          line_pop;
	logic                          res_push, res_pop;
	logic                          res_empty, res_full;
	result_t                       res_in, res_head;

	halfword_packer u_data_packer (
		.okClk        (okClk),
		.i_reset      (i_reset),
		.i_write      (i_pi_data_write),
		.i_word       (i_pi_data_word),
		.i_fifo_count (data_count),
		.o_ready      (o_pi_data_ready),
		.o_push       (data_push),
		.o_line       (data_line_in)
	);

	halfword_packer u_weig_packer (
		.okClk        (okClk),
		.i_reset      (i_reset),
		.i_write      (i_pi_weig_write),
		.i_word       (i_pi_weig_word),
		.i_fifo_count (weig_count),
		.o_ready      (o_pi_weig_ready),
		.o_push       (weig_push),
		.o_line       (weig_line_in)
	);

	sync_fifo #(.T_ENTRY(line_t), .DEPTH(`NPU_LINE_FIFO_DEPTH)) u_data_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_push  (data_push),
		.i_entry (data_line_in),
		.i_pop   (line_pop),
		.o_head  (data_head),
		.o_empty (data_empty),
		.o_full  (),         // throttle keeps it from filling
		.o_count (data_count)
	);

	sync_fifo #(.T_ENTRY(line_t), .DEPTH(`NPU_LINE_FIFO_DEPTH)) u_weig_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_push  (weig_push),
		.i_entry (weig_line_in),
		.i_pop   (line_pop),
		.o_head  (weig_head),
		.o_empty (weig_empty),
		.o_full  (),
		.o_count (weig_count)
	);

	dot_engine u_engine (
		.okClk         (okClk),
		.i_reset       (i_reset),
		.i_enable      (i_engine_enable),
		.i_bias        (half_t'(i_bias)),
		.i_data_line   (data_head),
		.i_data_empty  (data_empty),
		.i_weig_line   (weig_head),
		.i_weig_empty  (weig_empty),
		.i_result_full (res_full),
		.o_pop         (line_pop),
		.o_result_push (res_push),
		.o_result      (res_in)
	);

	sync_fifo #(.T_ENTRY(result_t), .DEPTH(`NPU_RESULT_FIFO_DEPTH)) u_result_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_push  (res_push),
		.i_entry (res_in),
		.i_pop   (res_pop),
		.o_head  (res_head),
		.o_empty (res_empty),
		.o_full  (res_full),
		.o_count ()
	);

	// host read only counts while a word is there
	assign o_po_ready = !res_empty;
	assign res_pop    = i_po_read && o_po_ready;
	assign o_po_word  = res_head;

endmodule

//--- rtl/dot_engine.sv
`timescale 1ns/1ps
`include "npu_consts.svh"

module dot_engine import npu_pkg::*; (
	input  logic    okClk,
	input  logic    i_reset,
	input  logic    i_enable,
	input  half_t   i_bias,
	input  line_t   i_data_line,
	input  logic    i_data_empty,
	input  line_t   i_weig_line,
	input  logic    i_weig_empty,
	input  logic    i_result_full,
	output logic    o_pop,
	output logic    o_result_push,
	output result_t o_result
);

	localparam int IDX_W = $clog2(`NPU_HALVES_PER_LINE);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACC,   // one product per cycle
		S_BIAS,
		S_PUSH   // waits here while the result FIFO is full
	} state_t;

	state_t           state;
	line_t            data_q;
	line_t            weig_q;
	half_t            bias_q;
	logic [IDX_W-1:0] idx;
	result_t          acc;
	result_t          result_q;
	result_t          prod;
	logic             start;

	assign start = (state == S_IDLE) && i_enable && !i_data_empty && !i_weig_empty;

	// one pop strobe serves both line FIFOs
	assign o_pop = start;

	// signed 16x16, fits in 32 bits
	assign prod = $signed(data_q[idx]) * $signed(weig_q[idx]);

	// operand and result registers
	always_ff @(posedge okClk) begin
		if (start) begin
			data_q <= i_data_line;
			weig_q <= i_weig_line;
			bias_q <= i_bias; // bias sampled with the pair
		end
		if (state == S_BIAS) begin
			result_q <= acc + {{(`NPU_RESULT_BITS - `NPU_HALF_BITS){bias_q[`NPU_HALF_BITS-1]}}, bias_q};
		end
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state <= S_IDLE;
			idx   <= '0;
			acc   <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						idx   <= '0;
						acc   <= '0;
						state <= S_ACC;
					end
				end
				S_ACC: begin
					acc <= acc + prod; // wraps modulo 2**32
					idx <= idx + 1'b1;
					if (idx == IDX_W'(`NPU_HALVES_PER_LINE - 1)) begin
						state <= S_BIAS;
					end
				end
				S_BIAS: begin
					state <= S_PUSH;
				end
				S_PUSH: begin
					if (!i_result_full) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// push lands 10 cycles after start when the result FIFO has room
	assign o_result_push = (state == S_PUSH) && !i_result_full;
	assign o_result      = result_q;

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
	parameter type T_ENTRY = logic [31:0],
	parameter int  DEPTH   = 16
) (
	input  logic                       okClk,
	input  logic                       i_reset,
	input  logic                       i_push,
	input  T_ENTRY                     i_entry,
	input  logic                       i_pop,
	output T_ENTRY                     o_head,
	output logic                       o_empty,
	output logic                       o_full,
	output logic [$clog2(DEPTH):0]     o_count
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH) + 1;

	T_ENTRY          mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;
	logic            push_ok;
	logic            pop_ok;

	assign push_ok = i_push && !o_full;  // push into a full buffer is lost
	assign pop_ok  = i_pop && !o_empty;

	// storage
	always_ff @(posedge okClk) begin
		if (push_ok) begin
			mem[wr_ptr] <= i_entry;
		end
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push_ok, pop_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// head falls through, valid whenever not empty
	assign o_head  = mem[rd_ptr];
	assign o_empty = (count == '0);
	assign o_full  = (count == CW'(DEPTH));
	assign o_count = count;

endmodule

//--- rtl/halfword_packer.sv
`timescale 1ns/1ps
`include "npu_consts.svh"

module halfword_packer import npu_pkg::*; (
	input  logic                          okClk,
	input  logic                          i_reset,
	input  logic                          i_write,
	input  logic [`NPU_PIPE_BITS-1:0]     i_word,
	input  logic [`NPU_LINE_COUNT_W-1:0]  i_fifo_count,
	output logic                          o_ready,
	output logic                          o_push,
	output line_t                         o_line
);

	localparam int CNT_W = $clog2(`NPU_HALVES_PER_LINE);

	logic [CNT_W-1:0]             half_cnt; // halfwords in the partial line
	logic [`NPU_LINE_BITS-1:0]    shift_q;
	logic [`NPU_LINE_COUNT_W-1:0] free_entries;
	logic                         last_half;

	assign last_half = (half_cnt == CNT_W'(`NPU_HALVES_PER_LINE - 1));

	// new halfword enters at the top and walks down, first one ends at bits 15:0
	always_ff @(posedge okClk) begin
		if (i_write) begin
			shift_q <= {i_word[`NPU_HALF_BITS-1:0], shift_q[`NPU_LINE_BITS-1:`NPU_HALF_BITS]};
		end
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			half_cnt <= '0; // drops any partial line
			o_push   <= 1'b0;
		end else begin
			o_push <= i_write && last_half; // line is complete in shift_q next cycle
			if (i_write) begin
				half_cnt <= last_half ? '0 : half_cnt + 1'b1;
			end
		end
	end

	assign o_line = line_t'(shift_q);

	// block throttle
	assign free_entries = `NPU_LINE_COUNT_W'(`NPU_LINE_FIFO_DEPTH) - i_fifo_count;

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			o_ready <= 1'b0;
		end else begin
			// count lags pushes by a cycle, headroom absorbs that
			if (free_entries >= `NPU_LINE_COUNT_W'(`NPU_HEADROOM_LINES)) begin
				o_ready <= 1'b1;
			end else begin
				o_ready <= 1'b0;
			end
		end
	end

endmodule

//--- rtl/npu_pkg.sv
`include "npu_consts.svh"

package npu_pkg;

	// one signed operand element
	typedef logic signed [`NPU_HALF_BITS-1:0] half_t;

	// element 0 sits in the low bits, it is the first halfword of the line
	typedef half_t [`NPU_HALVES_PER_LINE-1:0] line_t;

	// dot product plus bias, wraps modulo 2**32
	typedef logic signed [`NPU_RESULT_BITS-1:0] result_t;

endpackage

//--- include/npu_consts.svh
`ifndef NPU_CONSTS_SVH
`define NPU_CONSTS_SVH

// line geometry
`define NPU_HALF_BITS        16
`define NPU_HALVES_PER_LINE  8
`define NPU_LINE_BITS        (`NPU_HALF_BITS * `NPU_HALVES_PER_LINE)

// result word as seen on the pipe-out port
`define NPU_RESULT_BITS      32

// buffer depths, in entries
`define NPU_LINE_FIFO_DEPTH    16
`define NPU_RESULT_FIFO_DEPTH  16

// occupancy count width of a line FIFO, clog2(depth) + 1
`define NPU_LINE_COUNT_W     ($clog2(`NPU_LINE_FIFO_DEPTH) + 1)

// pipe-in ready needs at least this many free line entries
// one covers the registered ready, one the line still in the packer
`define NPU_HEADROOM_LINES   2

// host pipe word width, only the low halfword carries data
`define NPU_PIPE_BITS        32

`endif
